/* compile.f */
src/core_pkg.sv
src/core_if.sv
src/thread_pc_unit.sv
src/register_file.sv
src/instr_decoder.sv
src/alu_pipe.sv
src/barrel_core.sv
tb/tb_barrel_core.sv

/* src/alu_pipe.sv */
module alu_pipe (
   input  logic            clk,
   exec_if.receiver        ex,
   branch_if.driver        br,
   rf_write_if.driver      rf,
   output logic            st_valid_o,
   output core_pkg::word_t st_addr_o,
   output core_pkg::word_t st_data_o,
   output logic [3:0]      st_strobe_o
);
   import core_pkg::*;

   typedef struct packed {
      alu_op_e               op;
      branch_e               kind;
      logic                  wr_en;
      tid_t                  tid;
      logic [REG_ADDR_W-1:0] rd_addr;
      word_t                 pc;
      word_t                 base;
      word_t                 offset;
   } ctl_t;

   ctl_t        ctl_c3;
   ctl_t        ctl_c4;
   ctl_t        ctl_c5;
   ctl_t        ctl_c6;
   logic [5:0]  vld_q;
   logic        sub_op;
   word_t       b_add;
   logic [16:0] sum_lo_c4;
   logic [15:0] a_hi_c4;
   logic [15:0] b_hi_c4;
   logic [15:0] sum_hi;
   word_t       logic_c4;
   logic        sh_fill;
   logic [XLEN:0] sh_ext;
   word_t       sh1;
   word_t       sh_c4;
   logic        sh_fill_c4;
   logic [1:0]  sh_byte_c4;
   logic [XLEN:0] sh_ext2;
   word_t       sh2;
   logic        cmp_signed;
   logic        signed_c4;
   logic        a_msb_c4;
   logic        b_msb_c4;
   logic [3:0]  eq_c4;
   logic [3:0]  lt_c4;
   logic        ult_c4;
   logic        less_c4;
   logic        equal_c5;
   logic        less_c5;
   word_t       res_c5;
   logic        taken_c5;
   logic        taken_c6;
   word_t       res_c6;

   assign ctl_c3 = '{op: ex.alu_op, kind: ex.branch_kind, wr_en: ex.rf_wr_en, tid: ex.tid,
                     rd_addr: ex.rd_addr, pc: ex.pc, base: ex.target_base,
                     offset: ex.target_offset};

   assign sub_op     = (ex.alu_op == SUB);
   assign b_add      = sub_op ? ~ex.operand_b : ex.operand_b;
   assign sh_fill    = (ex.alu_op == SRA) & ex.operand_a[XLEN-1];
   assign sh_ext     = $signed({sh_fill, ex.operand_a}) >>> ex.shamt[2:0];
   assign sh1        = (ex.alu_op == SLL) ? (ex.operand_a << ex.shamt[2:0]) : sh_ext[XLEN-1:0];
   assign cmp_signed = (ex.alu_op == SLT) || (ex.branch_kind inside {BLT, BGE});

   // Fills after the first instruction out of reset reaches each stage
   always_ff @(posedge clk or posedge ex.c_sys_rst) begin
      if (ex.c_sys_rst) begin
         vld_q      <= '0;
         st_valid_o <= 1'b0;
      end else begin
         vld_q      <= {vld_q[4:0], 1'b1};
         st_valid_o <= ex.is_store & vld_q[2];
      end
   end

   // Stage c3 to c4: low adder half, logic, bit shift, byte compares, store
   always_ff @(posedge clk) begin
      sum_lo_c4  <= {1'b0, ex.operand_a[15:0]} + {1'b0, b_add[15:0]} + {16'b0, sub_op};
      a_hi_c4    <= ex.operand_a[31:16];
      b_hi_c4    <= b_add[31:16];
      case (ex.alu_op)
         AND:     logic_c4 <= ex.operand_a & ex.operand_b;
         OR:      logic_c4 <= ex.operand_a | ex.operand_b;
         XOR:     logic_c4 <= ex.operand_a ^ ex.operand_b;
         default: logic_c4 <= ex.operand_b;
      endcase
      sh_c4      <= sh1;
      sh_fill_c4 <= sh_fill;
      sh_byte_c4 <= ex.shamt[4:3];
      for (int i = 0; i < 4; i++) begin
         eq_c4[i] <= ex.operand_a[8*i +: 8] == ex.operand_b[8*i +: 8];
         lt_c4[i] <= ex.operand_a[8*i +: 8] < ex.operand_b[8*i +: 8];
      end
      signed_c4  <= cmp_signed;
      a_msb_c4   <= ex.operand_a[XLEN-1];
      b_msb_c4   <= ex.operand_b[XLEN-1];
      st_addr_o  <= ex.operand_a + ex.target_offset;
      st_data_o  <= ex.operand_b;
      case (ex.store_width)
         BYTE:    st_strobe_o <= 4'b0001;
         HALF:    st_strobe_o <= 4'b0011;
         WORD:    st_strobe_o <= 4'b1111;
         default: st_strobe_o <= 4'b0000;
      endcase
      ctl_c4     <= ctl_c3;
   end

   assign sum_hi  = a_hi_c4 + b_hi_c4 + {15'b0, sum_lo_c4[16]};
   assign sh_ext2 = $signed({sh_fill_c4, sh_c4}) >>> {sh_byte_c4, 3'b000};
   assign sh2     = (ctl_c4.op == SLL) ? (sh_c4 << {sh_byte_c4, 3'b000}) : sh_ext2[XLEN-1:0];
   assign ult_c4  = lt_c4[3] | (eq_c4[3] & lt_c4[2]) | (eq_c4[3] & eq_c4[2] & lt_c4[1]) |
                    (eq_c4[3] & eq_c4[2] & eq_c4[1] & lt_c4[0]);
   // Differing sign bits decide a signed compare on their own
   assign less_c4 = (signed_c4 && a_msb_c4 != b_msb_c4) ? a_msb_c4 : ult_c4;

   always_ff @(posedge clk) begin
      case (ctl_c4.op)
         ADD, SUB:      res_c5 <= {sum_hi, sum_lo_c4[15:0]};
         SLT, SLTU:     res_c5 <= word_t'(less_c4);
         SLL, SRL, SRA: res_c5 <= sh2;
         default:       res_c5 <= logic_c4;
      endcase
      equal_c5 <= &eq_c4;
      less_c5  <= less_c4;
      ctl_c5   <= ctl_c4;
   end

   always_comb begin
      case (ctl_c5.kind)
         BEQ:       taken_c5 = equal_c5;
         BNE:       taken_c5 = !equal_c5;
         BLT, BLTU: taken_c5 = less_c5;
         BGE, BGEU: taken_c5 = !less_c5;
         JUMP:      taken_c5 = 1'b1;
         default:   taken_c5 = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      taken_c6 <= taken_c5;
      res_c6   <= res_c5;
      ctl_c6   <= ctl_c5;
   end

   assign rf.wr_en   = ctl_c6.wr_en & vld_q[5];
   assign rf.tid     = ctl_c6.tid;
   assign rf.rd_addr = ctl_c6.rd_addr;
   assign rf.wr_data = res_c6;

   assign br.retire_valid  = vld_q[5];
   assign br.taken         = taken_c6;
   assign br.tid           = ctl_c6.tid;
   assign br.pc            = ctl_c6.pc;
   assign br.target_base   = ctl_c6.base;
   assign br.target_offset = ctl_c6.offset;

endmodule

/* src/barrel_core.sv */
module barrel_core (
   input  logic            clk,
   input  logic            c_sys_rst,
   output core_pkg::word_t pc_o,
   input  core_pkg::word_t instr_i,
   output logic            st_valid_o,
   output core_pkg::word_t st_addr_o,
   output core_pkg::word_t st_data_o,
   output logic [3:0]      st_strobe_o
);
   import core_pkg::*;

   tid_t                  fetch_tid;
   logic [REG_ADDR_W-1:0] rs1_addr;
   logic [REG_ADDR_W-1:0] rs2_addr;
   word_t                 rs1_data;
   word_t                 rs2_data;

   exec_if     ex_bus (.c_sys_rst(c_sys_rst));
   branch_if   br_bus ();
   rf_write_if wr_bus ();

   thread_pc_unit u_thread_pc (
      .clk       (clk),
      .c_sys_rst (c_sys_rst),
      .branch    (br_bus.receiver),
      .pc_o      (pc_o),
      .tid_o     (fetch_tid)
   );

   register_file u_register_file (
      .clk        (clk),
      .rs_tid_i   (fetch_tid),
      .rs1_addr_i (rs1_addr),
      .rs2_addr_i (rs2_addr),
      .rs1_data_o (rs1_data),
      .rs2_data_o (rs2_data),
      .wr         (wr_bus.receiver)
   );

   instr_decoder u_instr_decoder (
      .clk        (clk),
      .instr_i    (instr_i),
      .pc_i       (pc_o),
      .tid_i      (fetch_tid),
      .rs1_data_i (rs1_data),
      .rs2_data_i (rs2_data),
      .rs1_addr_o (rs1_addr),
      .rs2_addr_o (rs2_addr),
      .ex         (ex_bus.driver)
   );

   alu_pipe u_alu_pipe (
      .clk         (clk),
      .ex          (ex_bus.receiver),
      .br          (br_bus.driver),
      .rf          (wr_bus.driver),
      .st_valid_o  (st_valid_o),
      .st_addr_o   (st_addr_o),
      .st_data_o   (st_data_o),
      .st_strobe_o (st_strobe_o)
   );

endmodule

/* src/core_if.sv */
interface exec_if (input logic c_sys_rst);
   import core_pkg::*;

   alu_op_e               alu_op;
   branch_e               branch_kind;
   store_w_e              store_width;
   logic                  is_store;
   logic                  rf_wr_en;
   word_t                 operand_a;
   word_t                 operand_b;
   logic [4:0]            shamt;
   tid_t                  tid;
   logic [REG_ADDR_W-1:0] rd_addr;
   word_t                 target_base;
   word_t                 target_offset;
   word_t                 pc;

   modport driver (output alu_op, branch_kind, store_width, is_store, rf_wr_en,
                   operand_a, operand_b, shamt, tid, rd_addr,
                   target_base, target_offset, pc);
   modport receiver (input c_sys_rst, alu_op, branch_kind, store_width, is_store,
                     rf_wr_en, operand_a, operand_b, shamt, tid, rd_addr,
                     target_base, target_offset, pc);
endinterface

interface branch_if;
   import core_pkg::*;

   logic  retire_valid;
   logic  taken;
   tid_t  tid;
   word_t pc;
   word_t target_base;
   word_t target_offset;

   modport driver (output retire_valid, taken, tid, pc, target_base, target_offset);
   modport receiver (input retire_valid, taken, tid, pc, target_base, target_offset);
endinterface

interface rf_write_if;
   import core_pkg::*;

   logic                  wr_en;
   tid_t                  tid;
   logic [REG_ADDR_W-1:0] rd_addr;
   word_t                 wr_data;

   modport driver (output wr_en, tid, rd_addr, wr_data);
   modport receiver (input wr_en, tid, rd_addr, wr_data);
endinterface

/* src/core_pkg.sv */
package core_pkg;

   localparam int XLEN             = 32;
   localparam int NUM_THREADS      = 8;
   localparam int TID_W            = 3;
   localparam int REG_ADDR_W       = 5;
   localparam int THREAD_PC_STRIDE = 256;
   localparam int PC_STEP          = 4;

   typedef logic [XLEN-1:0]  word_t;
   typedef logic [TID_W-1:0] tid_t;

   // Major opcode, instruction bits 6:2
   typedef enum logic [4:0] {
      OP     = 5'b01100,
      OP_IMM = 5'b00100,
      LUI    = 5'b01101,
      AUIPC  = 5'b00101,
      BRANCH = 5'b11000,
      JAL    = 5'b11011,
      JALR   = 5'b11001,
      STORE  = 5'b01000
   } opcode_e;

   typedef enum logic [3:0] {
      ADD,
      SUB,
      AND,
      OR,
      XOR,
      SLT,
      SLTU,
      SLL,
      SRL,
      SRA,
      PASS_B
   } alu_op_e;

   typedef enum logic [2:0] {
      NONE,
      BEQ,
      BNE,
      BLT,
      BGE,
      BLTU,
      BGEU,
      JUMP
   } branch_e;

   // Same code as funct3 bits 1:0 of a store
   typedef enum logic [1:0] {
      BYTE = 2'b00,
      HALF = 2'b01,
      WORD = 2'b10
   } store_w_e;

endpackage

/* src/instr_decoder.sv */
module instr_decoder (
   input  logic                             clk,
   input  core_pkg::word_t                  instr_i,
   input  core_pkg::word_t                  pc_i,
   input  core_pkg::tid_t                   tid_i,
   input  core_pkg::word_t                  rs1_data_i,
   input  core_pkg::word_t                  rs2_data_i,
   output logic [core_pkg::REG_ADDR_W-1:0]  rs1_addr_o,
   output logic [core_pkg::REG_ADDR_W-1:0]  rs2_addr_o,
   exec_if.driver                           ex
);
   import core_pkg::*;

   word_t      pc_c1;
   word_t      pc_c2;
   tid_t       tid_c1;
   tid_t       tid_c2;
   word_t      instr_c2;
   opcode_e    opc;
   logic [2:0] funct3;
   logic       funct7_alt;
   logic       funct7_ok;
   logic       op_legal;
   logic       imm_legal;
   word_t      i_imm;
   word_t      s_imm;
   word_t      b_imm;
   word_t      u_imm;
   word_t      j_imm;
   alu_op_e    f3_op;
   alu_op_e    d_op;
   branch_e    d_br;
   logic       d_store;
   logic       d_wr;
   word_t      d_a;
   word_t      d_b;
   word_t      d_base;
   word_t      d_off;
   logic [4:0] d_shamt;

   assign rs1_addr_o = instr_i[19:15];
   assign rs2_addr_o = instr_i[24:20];

   always_ff @(posedge clk) begin
      pc_c1    <= pc_i;
      tid_c1   <= tid_i;
      pc_c2    <= pc_c1;
      tid_c2   <= tid_c1;
      instr_c2 <= instr_i;
   end

   assign opc        = opcode_e'(instr_c2[6:2]);
   assign funct3     = instr_c2[14:12];
   assign funct7_alt = instr_c2[30];
   assign funct7_ok  = (instr_c2[31:25] & 7'b1011111) == 7'b0;
   // Alternate funct7 only for sub and sra, or srai on the immediate side
   assign op_legal   = funct7_ok && (!funct7_alt || funct3 == 3'b000 || funct3 == 3'b101);
   assign imm_legal  = funct3[1:0] != 2'b01 || (funct7_ok && (!funct7_alt || funct3[2]));

   assign i_imm = {{20{instr_c2[31]}}, instr_c2[31:20]};
   assign s_imm = {{20{instr_c2[31]}}, instr_c2[31:25], instr_c2[11:7]};
   assign b_imm = {{19{instr_c2[31]}}, instr_c2[31], instr_c2[7], instr_c2[30:25],
                   instr_c2[11:8], 1'b0};
   assign u_imm = {instr_c2[31:12], 12'b0};
   assign j_imm = {{11{instr_c2[31]}}, instr_c2[31], instr_c2[19:12], instr_c2[20],
                   instr_c2[30:21], 1'b0};

   always_comb begin
      case (funct3)
         3'b000:  f3_op = (opc == OP && funct7_alt) ? SUB : ADD;
         3'b001:  f3_op = SLL;
         3'b010:  f3_op = SLT;
         3'b011:  f3_op = SLTU;
         3'b100:  f3_op = XOR;
         3'b101:  f3_op = funct7_alt ? SRA : SRL;
         3'b110:  f3_op = OR;
         default: f3_op = AND;
      endcase
   end

   // Defaults leave a no-op
   always_comb begin
      d_op    = f3_op;
      d_br    = NONE;
      d_store = 1'b0;
      d_wr    = 1'b0;
      d_a     = rs1_data_i;
      d_b     = rs2_data_i;
      d_base  = pc_c2;
      d_off   = b_imm;
      d_shamt = rs2_data_i[4:0];
      if (instr_c2[1:0] == 2'b11) begin
         case (opc)
            OP: begin
               d_wr = op_legal;
            end
            OP_IMM: begin
               d_wr    = imm_legal;
               d_b     = i_imm;
               d_shamt = instr_c2[24:20];
            end
            LUI: begin
               d_op = PASS_B;
               d_b  = u_imm;
               d_wr = 1'b1;
            end
            AUIPC: begin
               d_op = ADD;
               d_a  = pc_c2;
               d_b  = u_imm;
               d_wr = 1'b1;
            end
            JAL: begin
               d_op  = ADD;
               d_a   = pc_c2;
               d_b   = word_t'(PC_STEP);
               d_wr  = 1'b1;
               d_br  = JUMP;
               d_off = j_imm;
            end
            JALR: begin
               if (funct3 == 3'b000) begin
                  d_op   = ADD;
                  d_a    = pc_c2;
                  d_b    = word_t'(PC_STEP);
                  d_wr   = 1'b1;
                  d_br   = JUMP;
                  d_base = rs1_data_i;
                  d_off  = i_imm;
               end
            end
            BRANCH: begin
               case (funct3)
                  3'b000:  d_br = BEQ;
                  3'b001:  d_br = BNE;
                  3'b100:  d_br = BLT;
                  3'b101:  d_br = BGE;
                  3'b110:  d_br = BLTU;
                  3'b111:  d_br = BGEU;
                  default: d_br = NONE;
               endcase
            end
            STORE: begin
               // Offset rides in the target offset, b keeps rs2 as store data
               d_store = !funct3[2] && funct3[1:0] != 2'b11;
               d_off   = s_imm;
            end
            default: begin
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      ex.alu_op        <= d_op;
      ex.branch_kind   <= d_br;
      ex.store_width   <= store_w_e'(funct3[1:0]);
      ex.is_store      <= d_store;
      ex.rf_wr_en      <= d_wr;
      ex.operand_a     <= d_a;
      ex.operand_b     <= d_b;
      ex.shamt         <= d_shamt;
      ex.tid           <= tid_c2;
      ex.rd_addr       <= instr_c2[11:7];
      ex.target_base   <= d_base;
      ex.target_offset <= d_off;
      ex.pc            <= pc_c2;
   end

endmodule

/* src/register_file.sv */
module register_file (
   input  logic                             clk,
   input  core_pkg::tid_t                   rs_tid_i,
   input  logic [core_pkg::REG_ADDR_W-1:0]  rs1_addr_i,
   input  logic [core_pkg::REG_ADDR_W-1:0]  rs2_addr_i,
   output core_pkg::word_t                  rs1_data_o,
   output core_pkg::word_t                  rs2_data_o,
   rf_write_if.receiver                     wr
);
   import core_pkg::*;

   word_t bank [NUM_THREADS][2**REG_ADDR_W];
   tid_t  tid_c1;

   // rs_tid_i is the thread of the fetch cycle, addresses follow one cycle later
   always_ff @(posedge clk) begin
      tid_c1     <= rs_tid_i;
      rs1_data_o <= (rs1_addr_i == '0) ? '0 : bank[tid_c1][rs1_addr_i];
      rs2_data_o <= (rs2_addr_i == '0) ? '0 : bank[tid_c1][rs2_addr_i];
      if (wr.wr_en && wr.rd_addr != '0) begin
         bank[wr.tid][wr.rd_addr] <= wr.wr_data;
      end
   end

endmodule

/* src/thread_pc_unit.sv */
module thread_pc_unit (
   input  logic            clk,
   input  logic            c_sys_rst,
   branch_if.receiver      branch,
   output core_pkg::word_t pc_o,
   output core_pkg::tid_t  tid_o
);
   import core_pkg::*;

   tid_t  tid_q;
   word_t pc_tbl [NUM_THREADS];
   word_t next_pc;

   // Fixed round robin, wraps from the last thread to thread 0
   always_ff @(posedge clk or posedge c_sys_rst) begin
      if (c_sys_rst) begin
         tid_q <= '0;
      end else begin
         tid_q <= tid_q + 1'b1;
      end
   end

   always_comb begin
      if (branch.taken) begin
         next_pc = branch.target_base + branch.target_offset;
      end else begin
         next_pc = branch.pc + word_t'(PC_STEP);
      end
   end

   // Each thread starts at its own base
   always_ff @(posedge clk or posedge c_sys_rst) begin
      if (c_sys_rst) begin
         for (int t = 0; t < NUM_THREADS; t++) begin
            pc_tbl[t] <= word_t'(t * THREAD_PC_STRIDE);
         end
      end else begin
         if (branch.retire_valid) begin
            pc_tbl[branch.tid] <= next_pc;
         end
      end
   end

   // Retire lands two cycles before the same thread issues again
   assign pc_o  = pc_tbl[tid_q];
   assign tid_o = tid_q;

endmodule

/* tb/tb_barrel_core.sv */
module tb_barrel_core;
   timeunit 1ns;
   timeprecision 1ps;
   import core_pkg::*;

   localparam int MEM_WORDS   = NUM_THREADS * THREAD_PC_STRIDE / 4;
   localparam int RUN_LIMIT   = 600;
   localparam int DRAIN_LIMIT = 20;
   // Falling edges from instr_i to the store port
   localparam int STORE_LAT   = 3;
   localparam word_t HALT     = 32'h0000_006f;
   localparam logic [6:0] OPC_OP    = 7'b0110011;
   localparam logic [6:0] OPC_IMM   = 7'b0010011;
   localparam logic [6:0] OPC_LUI   = 7'b0110111;
   localparam logic [6:0] OPC_AUIPC = 7'b0010111;
   localparam logic [6:0] OPC_JALR  = 7'b1100111;

   logic       clk = 1'b0;
   logic       c_sys_rst;
   word_t      pc_o;
   word_t      instr_i;
   logic       st_valid_o;
   word_t      st_addr_o;
   word_t      st_data_o;
   logic [3:0] st_strobe_o;

   word_t      prog [MEM_WORDS];
   word_t      regs [NUM_THREADS][32];
   word_t      exp_pc [NUM_THREADS];
   logic       halted [NUM_THREADS];
   int         wp [NUM_THREADS];
   int         exp_due [$];
   word_t      exp_addr [$];
   word_t      exp_data [$];
   logic [3:0] exp_strb [$];
   integer     seed;
   int         cyc;
   int         err_cnt;
   int         pass_cnt;
   int         fail_cnt;
   logic       rst_req;
   logic       fetch_valid;
   word_t      fetch_pc;
   tid_t       rr_tid;
   string      test_name;

   barrel_core DUT (
      .clk         (clk),
      .c_sys_rst   (c_sys_rst),
      .pc_o        (pc_o),
      .instr_i     (instr_i),
      .st_valid_o  (st_valid_o),
      .st_addr_o   (st_addr_o),
      .st_data_o   (st_data_o),
      .st_strobe_o (st_strobe_o)
   );

   always #50 clk = ~clk;

   assert property (@(posedge clk) c_sys_rst |-> !st_valid_o)
      else begin
         err_cnt++;
         $display("%s: store port active while reset is high", test_name);
      end

   assert property (@(posedge clk) st_valid_o |-> st_strobe_o inside {4'b0001, 4'b0011, 4'b1111})
      else begin
         err_cnt++;
         $display("Error: %s strobe expected 0001, 0011 or 1111 actual %b", test_name, st_strobe_o);
      end

   function automatic word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd, input logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                   input logic [2:0] f3, input logic [4:0] rd,
                                   input logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
   endfunction

   function automatic word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
   endfunction

   function automatic word_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                   input logic [6:0] opc);
      return {imm, rd, opc};
   endfunction

   function automatic word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
   endfunction

   // ISA results, alt selects sub and sra
   function automatic word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a,
                                     input word_t b, input logic [4:0] sh);
      word_t r;
      case (f3)
         3'd0: r = alt ? a - b : a + b;
         3'd1: r = a << sh;
         3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'd3: r = (a < b) ? 32'd1 : 32'd0;
         3'd4: r = a ^ b;
         3'd5: begin
            if (alt) begin
               r = $signed(a) >>> sh;
            end else begin
               r = a >> sh;
            end
         end
         3'd6: r = a | b;
         default: r = a & b;
      endcase
      return r;
   endfunction

   function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
      case (f3)
         3'd0: return a == b;
         3'd1: return a != b;
         3'd4: return $signed(a) < $signed(b);
         3'd5: return $signed(a) >= $signed(b);
         3'd6: return a < b;
         3'd7: return a >= b;
         default: return 1'b0;
      endcase
   endfunction

   function automatic logic all_halted();
      for (int t = 0; t < NUM_THREADS; t++) begin
         if (!halted[t]) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   task automatic check_word(input string what, input word_t exp, input word_t act);
      assert (act === exp)
         else begin
            err_cnt++;
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
         end
   endtask

   // Runs one whole instruction of a thread, since its previous one has retired
   task automatic exec_model(input word_t pc, input word_t ins);
      tid_t       t;
      logic [4:0] rd;
      logic [2:0] f3;
      word_t      a;
      word_t      b;
      word_t      imm_i;
      word_t      res;
      word_t      nxt;
      logic       wr;
      t     = pc[10:8];
      rd    = ins[11:7];
      f3    = ins[14:12];
      a     = regs[t][ins[19:15]];
      b     = regs[t][ins[24:20]];
      imm_i = {{20{ins[31]}}, ins[31:20]};
      res   = '0;
      nxt   = pc + 32'd4;
      wr    = 1'b0;
      case (ins[6:0])
         OPC_OP: begin
            res = alu_ref(f3, ins[30], a, b, b[4:0]);
            wr  = 1'b1;
         end
         OPC_IMM: begin
            res = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i, ins[24:20]);
            wr  = 1'b1;
         end
         OPC_LUI: begin
            res = {ins[31:12], 12'b0};
            wr  = 1'b1;
         end
         OPC_AUIPC: begin
            res = pc + {ins[31:12], 12'b0};
            wr  = 1'b1;
         end
         7'b1101111: begin
            res = pc + 32'd4;
            nxt = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            wr  = 1'b1;
         end
         OPC_JALR: begin
            res = pc + 32'd4;
            nxt = a + imm_i;
            wr  = 1'b1;
         end
         7'b1100011: begin
            if (branch_ref(f3, a, b)) begin
               nxt = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            end
         end
         7'b0100011: begin
            exp_due.push_back(cyc + STORE_LAT);
            exp_addr.push_back(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
            exp_data.push_back(b);
            exp_strb.push_back(f3[1:0] == 2'b00 ? 4'b0001 : (f3[1:0] == 2'b01 ? 4'b0011 : 4'b1111));
         end
         default: begin
         end
      endcase
      if (wr && rd != 5'd0) begin
         regs[t][rd] = res;
      end
      exp_pc[t] = nxt;
      if (ins == HALT) begin
         halted[t] = 1'b1;
      end
   endtask

   task automatic check_store_port();
      if (exp_due.size() > 0 && exp_due[0] == cyc) begin
         assert (st_valid_o === 1'b1)
            else begin
               err_cnt++;
               $display("%s: store due at cycle %0d did not appear", test_name, cyc);
            end
         check_word("store address", exp_addr[0], st_addr_o);
         check_word("store data", exp_data[0], st_data_o);
         check_word("store strobe", word_t'(exp_strb[0]), word_t'(st_strobe_o));
         void'(exp_due.pop_front());
         void'(exp_addr.pop_front());
         void'(exp_data.pop_front());
         void'(exp_strb.pop_front());
      end else begin
         assert (st_valid_o === 1'b0)
            else begin
               err_cnt++;
               $display("%s: unexpected store at cycle %0d to %h", test_name, cyc, st_addr_o);
            end
      end
   endtask

   // One falling edge: memory reply, store check, then the next fetch address
   task automatic tick();
      @(negedge clk);
      cyc++;
      c_sys_rst = rst_req;
      if (fetch_valid && !c_sys_rst) begin
         instr_i = prog[fetch_pc[10:2]];
         exec_model(fetch_pc, instr_i);
      end else begin
         instr_i = enc_i(12'd0, 5'd0, 3'd0, 5'd0, OPC_IMM);
      end
      check_store_port();
      if (!c_sys_rst) begin
         check_word("pc of thread", exp_pc[rr_tid], pc_o);
         fetch_pc    = pc_o;
         fetch_valid = 1'b1;
         rr_tid      = rr_tid + 1'b1;
      end else begin
         fetch_valid = 1'b0;
      end
   endtask

   task automatic apply_reset();
      rst_req = 1'b1;
      repeat (3) tick();
      rst_req = 1'b0;
      exp_due.delete();
      exp_addr.delete();
      exp_data.delete();
      exp_strb.delete();
      for (int t = 0; t < NUM_THREADS; t++) begin
         exp_pc[t] = word_t'(t * THREAD_PC_STRIDE);
         halted[t] = 1'b0;
      end
      rr_tid = '0;
   endtask

   task automatic run_test(input string name);
      int n;
      test_name = name;
      err_cnt   = 0;
      apply_reset();
      n = 0;
      while (!all_halted() && n < RUN_LIMIT) begin
         tick();
         n++;
      end
      if (!all_halted()) begin
         err_cnt++;
         $display("%s: not every thread reached its halt loop in time", name);
      end
      n = 0;
      while (exp_due.size() > 0 && n < DRAIN_LIMIT) begin
         tick();
         n++;
      end
      if (exp_due.size() > 0) begin
         err_cnt++;
         $display("%s: %0d stores still pending", name, exp_due.size());
      end
      // Let the halt loops retire and issue once more
      repeat (2 * NUM_THREADS) tick();
      if (err_cnt == 0) begin
         pass_cnt++;
         $display("Test %s: ok", name);
      end else begin
         fail_cnt++;
         $display("Test %s: FAILED with %0d errors", name, err_cnt);
      end
   endtask

   task automatic emit(input int t, input word_t w);
      prog[t * THREAD_PC_STRIDE / 4 + wp[t]] = w;
      wp[t]++;
   endtask

   task automatic load_const(input int t, input logic [4:0] rd, input word_t v);
      logic [19:0] hi;
      hi = v[31:12] + {19'b0, v[11]};
      emit(t, enc_u(hi, rd, OPC_LUI));
      emit(t, enc_i(v[11:0], rd, 3'd0, rd, OPC_IMM));
   endtask

   // Unused words are harmless x0 writes carrying their own index
   task automatic clear_programs();
      for (int i = 0; i < MEM_WORDS; i++) begin
         prog[i] = enc_i(12'(i), 5'd0, 3'd0, 5'd0, OPC_IMM);
      end
      for (int t = 0; t < NUM_THREADS; t++) begin
         wp[t] = 0;
      end
   endtask

   task automatic build_rotation();
      clear_programs();
      for (int t = 0; t < NUM_THREADS; t++) begin
         for (int i = 0; i < 3; i++) begin
            emit(t, enc_i(12'(t + i), 5'd0, 3'd0, 5'd0, OPC_IMM));
         end
         emit(t, HALT);
      end
   endtask

   task automatic build_alu();
      word_t      rnd;
      logic [2:0] f3;
      logic [6:0] f7;
      logic [11:0] imm;
      clear_programs();
      for (int t = 0; t < NUM_THREADS; t++) begin
         load_const(t, 5'd1, $random(seed));
         load_const(t, 5'd2, $random(seed));
         emit(t, enc_s(12'd200, 5'd1, 5'd0, 3'd2));
         emit(t, enc_s(12'd204, 5'd2, 5'd0, 3'd2));
         // Eight funct3 codes, then sub and sra
         for (int i = 0; i < 10; i++) begin
            f3 = (i < 8) ? 3'(i) : ((i == 8) ? 3'd0 : 3'd5);
            f7 = (i < 8) ? 7'b0 : 7'b0100000;
            emit(t, enc_r(f7, 5'd2, 5'd1, f3, 5'd3, OPC_OP));
            emit(t, enc_s(12'(4 * i), 5'd3, 5'd0, 3'd2));
         end
         for (int i = 0; i < 9; i++) begin
            f3  = (i < 8) ? 3'(i) : 3'd5;
            rnd = $random(seed);
            imm = rnd[11:0];
            if (f3 == 3'd1 || f3 == 3'd5) begin
               imm = {(i == 8) ? 7'b0100000 : 7'b0, rnd[4:0]};
            end
            emit(t, enc_i(imm, 5'd1, f3, 5'd3, OPC_IMM));
            emit(t, enc_s(12'(64 + 4 * i), 5'd3, 5'd0, 3'd2));
         end
         emit(t, HALT);
      end
   endtask

   task automatic build_stores();
      word_t rnd;
      clear_programs();
      for (int t = 0; t < NUM_THREADS; t++) begin
         load_const(t, 5'd1, $random(seed));
         load_const(t, 5'd2, $random(seed));
         for (int w = 0; w < 3; w++) begin
            rnd = $random(seed);
            emit(t, enc_s(rnd[11:0], 5'd2, 5'd1, 3'(w)));
         end
         emit(t, HALT);
      end
   endtask

   // x1 positive, x2 negative, x3 a copy of x1
   task automatic build_branches();
      word_t      rnd;
      logic [2:0] f3;
      logic [4:0] rs1;
      logic [4:0] rs2;
      clear_programs();
      for (int t = 0; t < NUM_THREADS; t++) begin
         rnd = $random(seed);
         load_const(t, 5'd1, {1'b0, rnd[30:0]});
         rnd = $random(seed);
         load_const(t, 5'd2, {1'b1, rnd[30:0]});
         emit(t, enc_i(12'd0, 5'd1, 3'd0, 5'd3, OPC_IMM));
         emit(t, enc_i(12'd0, 5'd0, 3'd0, 5'd5, OPC_IMM));
         for (int c = 0; c < 6; c++) begin
            f3 = (c < 2) ? 3'(c) : 3'(c + 2);
            for (int p = 0; p < 3; p++) begin
               rs1 = (p == 1) ? 5'd2 : 5'd1;
               rs2 = (p == 0) ? 5'd2 : ((p == 1) ? 5'd1 : 5'd3);
               emit(t, enc_b(13'd8, rs2, rs1, f3));
               emit(t, enc_i(12'd1, 5'd5, 3'd0, 5'd5, OPC_IMM));
            end
         end
         emit(t, enc_s(12'd0, 5'd5, 5'd0, 3'd2));
         emit(t, HALT);
      end
   endtask

   task automatic build_jumps();
      word_t rnd;
      clear_programs();
      for (int t = 0; t < NUM_THREADS; t++) begin
         rnd = $random(seed);
         emit(t, enc_j(21'd8, 5'd1));
         emit(t, enc_i(12'd1, 5'd0, 3'd0, 5'd6, OPC_IMM));
         emit(t, enc_s(12'd0, 5'd1, 5'd0, 3'd2));
         emit(t, enc_u(rnd[19:0], 5'd2, OPC_AUIPC));
         emit(t, enc_s(12'd4, 5'd2, 5'd0, 3'd2));
         emit(t, enc_u(20'd0, 5'd3, OPC_AUIPC));
         emit(t, enc_i(12'd12, 5'd3, 3'd0, 5'd4, OPC_JALR));
         emit(t, enc_i(12'd2, 5'd0, 3'd0, 5'd6, OPC_IMM));
         emit(t, enc_s(12'd8, 5'd4, 5'd0, 3'd2));
         emit(t, HALT);
      end
   endtask

   task automatic build_isolation();
      word_t rnd;
      clear_programs();
      for (int t = 0; t < NUM_THREADS; t++) begin
         rnd = $random(seed);
         load_const(t, 5'd7, {3'(t), rnd[28:0]});
         emit(t, enc_s(12'd0, 5'd7, 5'd0, 3'd2));
         emit(t, enc_i(12'd0, 5'd7, 3'd0, 5'd0, OPC_IMM));
         emit(t, enc_s(12'd4, 5'd0, 5'd0, 3'd2));
         emit(t, HALT);
      end
   endtask

   initial begin
      c_sys_rst   = 1'b1;
      instr_i     = '0;
      rst_req     = 1'b1;
      fetch_valid = 1'b0;
      fetch_pc    = '0;
      rr_tid      = '0;
      seed        = 32'hb88e9423;
      cyc         = 0;
      err_cnt     = 0;
      pass_cnt    = 0;
      fail_cnt    = 0;
      test_name   = "startup";
      for (int t = 0; t < NUM_THREADS; t++) begin
         for (int r = 0; r < 32; r++) begin
            regs[t][r] = '0;
         end
      end

      build_rotation();
      run_test("reset_rotation");
      build_alu();
      run_test("alu_results");
      build_stores();
      run_test("store_format");
      build_branches();
      run_test("branches");
      build_jumps();
      run_test("jumps_linking");
      build_isolation();
      run_test("thread_isolation");

      $display("Tests run: %0d, ok: %0d, failed: %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule
